//--- source/pktgen_defines.svh
////////////////////////////////////////////////////////////
// Generator sizing macros for register count, payload length,
// source MAC and shaper cost per packet
////////////////////////////////////////////////////////////

`ifndef PKTGEN_DEFINES_SVH
`define PKTGEN_DEFINES_SVH

// Number of 32-bit registers in the bank
`define PKTGEN_NUM_REGS 8

// Payload length in 32-bit words
`define PKTGEN_PKT_WORDS 10

// Fixed source MAC of every frame
`define PKTGEN_SRC_MAC 48'haa_aa_aa_aa_bb_aa

// Whole part added to the shaper accumulator per packet
// and equal to the frame length in bytes
`define PKTGEN_SHAPER_COST 74

`endif

//--- source/avmm_regs_pkg.sv
////////////////////////////////////////////////////////////
// Bus request/response structs, register indexes, run controls
////////////////////////////////////////////////////////////

`default_nettype none

package avmm_regs_pkg;

    typedef struct packed {
        logic [2:0]  address;
        logic        write;
        logic        read;
        logic [31:0] writedata;
    } avmm_req_t;

    typedef struct packed {
        logic [31:0] readdata;
        logic        readdatavalid;
    } avmm_rsp_t;

    typedef enum logic [2:0] {
        REG_CTRL        = 3'd0,     // Bit 0 start, bit 1 continuous
        REG_NUM_PACKETS = 3'd1,
        REG_SHAPER_DEC  = 3'd2,     // 15.16 fixed point
        REG_TTL_PROTO   = 3'd3,
        REG_SRC_IP      = 3'd4,
        REG_DST_IP      = 3'd5,
        REG_DST_MAC_HI  = 3'd6,
        REG_DST_MAC_LO  = 3'd7
    } reg_index_t;

    typedef struct packed {
        logic [31:0] num_packets;
        logic        continuous;
        logic [30:0] shaper_dec;    // 15.16 fixed point
    } run_ctrl_t;

endpackage

`default_nettype wire

//--- source/ipv4_frame_pkg.sv
////////////////////////////////////////////////////////////
// Frame field and stream byte structs, sequencer states, lengths
////////////////////////////////////////////////////////////

`include "pktgen_defines.svh"

`default_nettype none

package ipv4_frame_pkg;

    // IPv4 header plus payload, in bytes
    localparam int ip_total_length = 20 + 4 * `PKTGEN_PKT_WORDS;

    // Ethernet header plus IPv4 packet
    localparam int frame_bytes = 14 + ip_total_length;

    typedef struct packed {
        logic [47:0] dst_mac;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
    } frame_fields_t;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } stream_byte_t;

    ////////////////////////////////////////////////////////////
    // Sequencer states as read back in REG_CTRL bits 7:0

    typedef enum logic [1:0] {
        SEQ_IDLE         = 2'd0,
        SEQ_WAIT_HEADER  = 2'd1,
        SEQ_NEXT_PACKET  = 2'd2,
        SEQ_WAIT_SENDING = 2'd3
    } seq_state_t;

endpackage

`default_nettype wire

//--- source/avmm_reg_bank.sv
////////////////////////////////////////////////////////////
// Register bank with bus decode, start strobe and status readback
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "pktgen_defines.svh"

`default_nettype none

module avmm_reg_bank (
    input  logic                          clk_ifc_avmm,
    input  logic                          rst_n,
    input  avmm_regs_pkg::avmm_req_t      bus_req,
    output avmm_regs_pkg::avmm_rsp_t      bus_rsp,
    output avmm_regs_pkg::run_ctrl_t      run_ctrl,
    output logic                          start,
    output ipv4_frame_pkg::frame_fields_t fields,
    input  ipv4_frame_pkg::seq_state_t    state,
    input  logic [31:0]                   remaining,
    input  logic [31:0]                   shaper_accum,
    input  logic [31:0]                   tx_count,
    input  logic                          busy
);

    logic [31:0] regs [`PKTGEN_NUM_REGS];
    logic [31:0] ctrl_status;

    // Sequencer busy, serializer busy, state
    assign ctrl_status = {state != ipv4_frame_pkg::SEQ_IDLE, busy, 22'h0, 8'(state)};

    ////////////////////////////////////////////////////////////
    // Writes and start strobe

    always_ff @(posedge clk_ifc_avmm) begin
        if (!rst_n) begin
            for (int i = 0; i < `PKTGEN_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            start <= 1'b0;
        end else begin
            start <= bus_req.write && bus_req.writedata[0] &&
                     bus_req.address == avmm_regs_pkg::REG_CTRL;
            if (bus_req.write) begin
                regs[bus_req.address] <= bus_req.writedata;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Reads, one cycle latency

    always_ff @(posedge clk_ifc_avmm) begin
        if (!rst_n) begin
            bus_rsp.readdatavalid <= 1'b0;
        end else begin
            bus_rsp.readdatavalid <= bus_req.read;
        end
    end

    always_ff @(posedge clk_ifc_avmm) begin
        case (avmm_regs_pkg::reg_index_t'(bus_req.address))
            avmm_regs_pkg::REG_CTRL:        bus_rsp.readdata <= ctrl_status;
            avmm_regs_pkg::REG_NUM_PACKETS: bus_rsp.readdata <= remaining;
            avmm_regs_pkg::REG_SHAPER_DEC:  bus_rsp.readdata <= shaper_accum;
            avmm_regs_pkg::REG_DST_MAC_LO:  bus_rsp.readdata <= tx_count;   // Low word only
            default:                        bus_rsp.readdata <= regs[bus_req.address];
        endcase
    end

    // Register fields onto the run controls and frame fields
    assign run_ctrl.num_packets = regs[avmm_regs_pkg::REG_NUM_PACKETS];
    assign run_ctrl.continuous  = regs[avmm_regs_pkg::REG_CTRL][1];
    assign run_ctrl.shaper_dec  = regs[avmm_regs_pkg::REG_SHAPER_DEC][30:0];

    assign fields.dst_mac  = {regs[avmm_regs_pkg::REG_DST_MAC_HI][15:0],
                              regs[avmm_regs_pkg::REG_DST_MAC_LO]};
    assign fields.ttl      = regs[avmm_regs_pkg::REG_TTL_PROTO][15:8];
    assign fields.protocol = regs[avmm_regs_pkg::REG_TTL_PROTO][7:0];
    assign fields.src_ip   = regs[avmm_regs_pkg::REG_SRC_IP];
    assign fields.dst_ip   = regs[avmm_regs_pkg::REG_DST_IP];

endmodule

`default_nettype wire

//--- source/packet_sequencer.sv
////////////////////////////////////////////////////////////
// Packet sequencer FSM with rate shaper and transmit counter
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "pktgen_defines.svh"

`default_nettype none

module packet_sequencer (
    input  logic                       clk_ifc_avmm,
    input  logic                       rst_n,
    input  avmm_regs_pkg::run_ctrl_t   run_ctrl,
    input  logic                       start,
    input  logic                       hdr_ready,
    input  logic                       frame_done,
    output logic                       frame_start,
    output logic [31:0]                packet_id,
    output ipv4_frame_pkg::seq_state_t state,
    output logic [31:0]                remaining,
    output logic [31:0]                shaper_accum,
    output logic [31:0]                tx_count
);

    // Per packet credit in 1.15.16 format
    localparam logic [31:0] shaper_step = {16'(`PKTGEN_SHAPER_COST), 16'h0000};

    logic run_continuous;   // Continuous bit sampled at start
    logic run_done;
    logic shaper_open;

    // Burst ends on zero remaining, continuous ends when software clears the bit
    assign run_done    = run_continuous ? !run_ctrl.continuous : (remaining == 32'd0);
    assign shaper_open = shaper_accum[31] || !run_continuous;

    always_ff @(posedge clk_ifc_avmm) begin
        if (!rst_n) begin
            state          <= ipv4_frame_pkg::SEQ_IDLE;
            frame_start    <= 1'b0;
            packet_id      <= '0;
            remaining      <= '0;
            run_continuous <= 1'b0;
            tx_count       <= '0;
        end else begin
            frame_start <= 1'b0;
            if (frame_done && tx_count != '1) begin
                tx_count <= tx_count + 32'd1;   // Saturating
            end
            case (state)
                ipv4_frame_pkg::SEQ_IDLE: begin
                    if (start) begin
                        remaining      <= run_ctrl.num_packets;
                        run_continuous <= run_ctrl.continuous;
                        packet_id      <= '0;
                        tx_count       <= '0;
                        state          <= ipv4_frame_pkg::SEQ_WAIT_HEADER;
                    end
                end
                ipv4_frame_pkg::SEQ_WAIT_HEADER: begin
                    if (run_done) begin
                        state <= ipv4_frame_pkg::SEQ_IDLE;
                    end else if (hdr_ready && shaper_open) begin
                        state <= ipv4_frame_pkg::SEQ_NEXT_PACKET;
                    end
                end
                ipv4_frame_pkg::SEQ_NEXT_PACKET: begin
                    remaining   <= run_continuous ? 32'd0 : remaining - 32'd1;
                    packet_id   <= packet_id + 32'd1;
                    frame_start <= 1'b1;    // Carries the new id
                    state       <= ipv4_frame_pkg::SEQ_WAIT_SENDING;
                end
                default: begin
                    if (frame_done) begin
                        state <= ipv4_frame_pkg::SEQ_WAIT_HEADER;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Rate shaper, signed 1.15.16 accumulator

    always_ff @(posedge clk_ifc_avmm) begin
        if (!rst_n) begin
            shaper_accum <= '0;
        end else if (state == ipv4_frame_pkg::SEQ_IDLE) begin
            shaper_accum <= '0;
        end else if (state == ipv4_frame_pkg::SEQ_NEXT_PACKET) begin
            shaper_accum <= shaper_accum + shaper_step - {1'b0, run_ctrl.shaper_dec};
        end else if (!(shaper_accum[31] && !shaper_accum[30])) begin
            shaper_accum <= shaper_accum - {1'b0, run_ctrl.shaper_dec};   // Stops near -2^30
        end
    end

endmodule

`default_nettype wire

//--- source/ipv4_frame_serializer.sv
////////////////////////////////////////////////////////////
// IPv4 header checksum and byte-wide frame emission
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "pktgen_defines.svh"

`default_nettype none

module ipv4_frame_serializer (
    input  logic                          clk_ifc_avmm,
    input  logic                          rst_n,
    input  ipv4_frame_pkg::frame_fields_t fields,
    input  logic                          frame_start,
    input  logic [31:0]                   packet_id,
    output logic                          hdr_ready,
    output logic                          frame_done,
    output ipv4_frame_pkg::stream_byte_t  tx_byte,
    output logic                          tx_valid,
    input  logic                          tx_ready
);

    // Ethernet plus IPv4 header bytes
    localparam int hdr_len = ipv4_frame_pkg::frame_bytes - 4 * `PKTGEN_PKT_WORDS;
    localparam logic [6:0] last_idx = 7'(ipv4_frame_pkg::frame_bytes - 1);

    logic [6:0]             byte_idx;
    logic [6:0]             payload_off;
    logic [31:0]            id_q;
    logic [15:0]            csum;
    logic [8*hdr_len-1:0]   hdr_bytes;

    // One's-complement sum over the ten header words with the checksum word as zero
    function automatic logic [15:0] header_checksum(input ipv4_frame_pkg::frame_fields_t f,
                                                    input logic [15:0] ident);
        logic [19:0] sum;
        sum = 20'h04500 + 20'(ipv4_frame_pkg::ip_total_length) + 20'(ident) + 20'h04000;
        sum = sum + 20'({f.ttl, f.protocol});
        sum = sum + 20'(f.src_ip[31:16]) + 20'(f.src_ip[15:0]);
        sum = sum + 20'(f.dst_ip[31:16]) + 20'(f.dst_ip[15:0]);
        sum = 20'(sum[15:0]) + 20'(sum[19:16]);     // Two folds clear any carry
        sum = 20'(sum[15:0]) + 20'(sum[19:16]);
        return ~sum[15:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // Frame control

    always_ff @(posedge clk_ifc_avmm) begin
        if (!rst_n) begin
            tx_valid <= 1'b0;
            byte_idx <= '0;
        end else if (frame_start) begin
            tx_valid <= 1'b1;
            byte_idx <= '0;
        end else if (tx_valid && tx_ready) begin
            if (tx_byte.last) begin
                tx_valid <= 1'b0;
            end else begin
                byte_idx <= byte_idx + 7'd1;
            end
        end
    end

    always_ff @(posedge clk_ifc_avmm) begin
        if (frame_start) begin
            id_q <= packet_id;
            csum <= header_checksum(fields, packet_id[15:0]);
        end
    end

    assign hdr_ready  = !tx_valid;
    assign frame_done = tx_valid && tx_ready && tx_byte.last;

    ////////////////////////////////////////////////////////////
    // Byte select

    // Ethernet header, then IPv4 header with DF set and no options
    assign hdr_bytes = {fields.dst_mac, `PKTGEN_SRC_MAC, 16'h0800,
                        8'h45, 8'h00, 16'(ipv4_frame_pkg::ip_total_length),
                        id_q[15:0], 16'h4000, fields.ttl, fields.protocol, csum,
                        fields.src_ip, fields.dst_ip};

    assign payload_off = byte_idx - 7'(hdr_len);

    always_comb begin
        if (byte_idx < 7'(hdr_len)) begin
            tx_byte.data = hdr_bytes[8*hdr_len - 1 - 8*int'(byte_idx) -: 8];
        end else begin
            tx_byte.data = id_q[31 - 8*int'(payload_off[1:0]) -: 8];   // Id MSB first
        end
        tx_byte.last = (byte_idx == last_idx);
    end

endmodule

`default_nettype wire

//--- source/ipv4_packet_src.sv
////////////////////////////////////////////////////////////
// IPv4 test packet generator top level
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`default_nettype none

module ipv4_packet_src (
    input  logic                         clk_ifc_avmm,
    input  logic                         rst_n,
    input  avmm_regs_pkg::avmm_req_t     bus_req,
    output avmm_regs_pkg::avmm_rsp_t     bus_rsp,
    output ipv4_frame_pkg::stream_byte_t tx_byte,
    output logic                         tx_valid,
    input  logic                         tx_ready
);

    avmm_regs_pkg::run_ctrl_t      run_ctrl;
    ipv4_frame_pkg::frame_fields_t fields;
    ipv4_frame_pkg::seq_state_t    state;
    logic                          start;
    logic                          frame_start;
    logic [31:0]                   packet_id;
    logic                          hdr_ready;
    logic                          frame_done;
    logic [31:0]                   remaining;
    logic [31:0]                   shaper_accum;
    logic [31:0]                   tx_count;

    avmm_reg_bank u_reg_bank (
        .clk_ifc_avmm (clk_ifc_avmm),
        .rst_n        (rst_n),
        .bus_req      (bus_req),
        .bus_rsp      (bus_rsp),
        .run_ctrl     (run_ctrl),
        .start        (start),
        .fields       (fields),
        .state        (state),
        .remaining    (remaining),
        .shaper_accum (shaper_accum),
        .tx_count     (tx_count),
        .busy         (!hdr_ready)      // Serializer mid-frame
    );

    packet_sequencer u_sequencer (
        .clk_ifc_avmm (clk_ifc_avmm),
        .rst_n        (rst_n),
        .run_ctrl     (run_ctrl),
        .start        (start),
        .hdr_ready    (hdr_ready),
        .frame_done   (frame_done),
        .frame_start  (frame_start),
        .packet_id    (packet_id),
        .state        (state),
        .remaining    (remaining),
        .shaper_accum (shaper_accum),
        .tx_count     (tx_count)
    );

    ipv4_frame_serializer u_serializer (
        .clk_ifc_avmm (clk_ifc_avmm),
        .rst_n        (rst_n),
        .fields       (fields),
        .frame_start  (frame_start),
        .packet_id    (packet_id),
        .hdr_ready    (hdr_ready),
        .frame_done   (frame_done),
        .tx_byte      (tx_byte),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready)
    );

endmodule

`default_nettype wire

//--- verification/tb_ipv4_packet_src.sv
////////////////////////////////////////////////////////////
// Trace-driven testbench with bus tasks, frame model and stream checker
////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "pktgen_defines.svh"

`default_nettype none

module tb_ipv4_packet_src;

    localparam int hdr_len       = 34;     // Ethernet plus IPv4 header
    localparam int frame_len     = hdr_len + 4 * `PKTGEN_PKT_WORDS;
    localparam int frame_timeout = 4000;   // Cycles allowed per frame
    localparam int idle_polls    = 1000;

    logic                         clk_ifc_avmm = 1'b0;
    logic                         rst_n;
    avmm_regs_pkg::avmm_req_t     bus_req;
    avmm_regs_pkg::avmm_rsp_t     bus_rsp;
    ipv4_frame_pkg::stream_byte_t tx_byte;
    logic                         tx_valid;
    logic                         tx_ready = 1'b1;

    logic [31:0] shadow [8];             // Last value written per register
    logic [7:0]  exp_frame [frame_len];
    logic [8:0]  rx_q [$];               // Captured {last, data}
    logic        bp_on = 1'b0;
    integer      seed = 32'h06c54c0d;
    int          errors = 0;
    int          timeouts = 0;

    ipv4_packet_src i_dut (
        .clk_ifc_avmm (clk_ifc_avmm),
        .rst_n        (rst_n),
        .bus_req      (bus_req),
        .bus_rsp      (bus_rsp),
        .tx_byte      (tx_byte),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready)
    );

    always #4 clk_ifc_avmm = ~clk_ifc_avmm;

    // Random tready gaps while back-pressure is on
    always @(posedge clk_ifc_avmm) begin
        #1;
        tx_ready = bp_on ? ($random(seed) % 3 != 0) : 1'b1;
    end

    // Handshakes sampled between edges
    always @(negedge clk_ifc_avmm) begin
        if (rst_n && tx_valid && tx_ready) begin
            rx_q.push_back({tx_byte.last, tx_byte.data});
        end
    end

    ////////////////////////////////////////////////////////////
    // Bus access

    task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
        @(posedge clk_ifc_avmm);
        #1;
        bus_req.address   = addr;
        bus_req.writedata = data;
        bus_req.write     = 1'b1;
        @(posedge clk_ifc_avmm);
        #1;
        bus_req.write = 1'b0;
        shadow[addr]  = data;
    endtask

    task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
        @(posedge clk_ifc_avmm);
        #1;
        bus_req.address = addr;
        bus_req.read    = 1'b1;
        @(posedge clk_ifc_avmm);
        #1;
        bus_req.read = 1'b0;
        assert (bus_rsp.readdatavalid === 1'b1) else begin
            $display("error at %0t: bus_rsp.readdatavalid = %b, expected 1",
                     $time, bus_rsp.readdatavalid);
            errors++;
        end
        data = bus_rsp.readdata;
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Frame model and checker

    task automatic build_frame(input logic [31:0] id);
        logic [47:0]  dmac;
        logic [47:0]  smac;
        logic [159:0] ip;
        logic [31:0]  sum;
        logic [15:0]  csum;
        dmac = {shadow[6][15:0], shadow[7]};
        smac = `PKTGEN_SRC_MAC;
        for (int i = 0; i < 6; i++) begin
            exp_frame[i]     = dmac[47 - 8*i -: 8];
            exp_frame[i + 6] = smac[47 - 8*i -: 8];
        end
        exp_frame[12] = 8'h08;
        exp_frame[13] = 8'h00;
        // Checksum word zero until summed
        ip = {8'h45, 8'h00, 16'(frame_len - 14), id[15:0], 16'h4000,
              shadow[3][15:0], 16'h0000, shadow[4], shadow[5]};
        for (int i = 0; i < 20; i++) begin
            exp_frame[14 + i] = ip[159 - 8*i -: 8];
        end
        sum = 32'h0;
        for (int i = 0; i < 20; i += 2) begin
            sum = sum + 32'({exp_frame[14 + i], exp_frame[15 + i]});
        end
        while (sum[31:16] != 16'h0) begin
            sum = 32'(sum[15:0]) + 32'(sum[31:16]);    // End-around carry
        end
        csum = ~sum[15:0];
        exp_frame[24] = csum[15:8];
        exp_frame[25] = csum[7:0];
        for (int i = hdr_len; i < frame_len; i++) begin
            exp_frame[i] = id[31 - 8*((i - hdr_len) % 4) -: 8];
        end
    endtask

    task automatic check_frame(input logic [31:0] id);
        logic [8:0] got;
        int         cycles;
        cycles = 0;
        while (rx_q.size() < frame_len && cycles < frame_timeout) begin
            @(posedge clk_ifc_avmm);
            cycles++;
        end
        if (rx_q.size() < frame_len) begin
            $display("timeout waiting for the frame with id %0d", id);
            timeouts++;
        end else begin
            build_frame(id);
            for (int i = 0; i < frame_len; i++) begin
                got = rx_q.pop_front();
                assert (got[7:0] === exp_frame[i]) else begin
                    $display("error at %0t: tx_byte.data (id %0d, byte %0d) = %h, expected %h",
                             $time, id, i, got[7:0], exp_frame[i]);
                    errors++;
                end
                assert (got[8] === (i == frame_len - 1)) else begin
                    $display("error at %0t: tx_byte.last (id %0d, byte %0d) = %b, expected %b",
                             $time, id, i, got[8], i == frame_len - 1);
                    errors++;
                end
            end
        end
    endtask

    // Status while the first frame of a burst is on the stream
    task automatic check_busy_status();
        logic [31:0] status;
        int          cycles;
        cycles = 0;
        while (tx_valid !== 1'b1 && cycles < frame_timeout) begin
            @(posedge clk_ifc_avmm);
            #1;
            cycles++;
        end
        if (tx_valid !== 1'b1) begin
            $display("timeout waiting for the first byte of the burst");
            timeouts++;
        end else begin
            read_reg(avmm_regs_pkg::REG_CTRL, status);
            compare_word("status during frame", status,
                         {1'b1, 1'b1, 22'h0, 8'(ipv4_frame_pkg::SEQ_WAIT_SENDING)});
        end
    endtask

    // Polls the status word until the sequencer reports idle
    task automatic wait_idle();
        logic [31:0] status;
        int          polls;
        status = 32'hffff_ffff;
        polls  = 0;
        while (status[31] && polls < idle_polls) begin
            read_reg(avmm_regs_pkg::REG_CTRL, status);
            polls++;
        end
        if (status[31]) begin
            $display("timeout waiting for the sequencer to return to idle");
            timeouts++;
        end
    endtask

    task automatic check_no_extra_bytes();
        assert (rx_q.size() == 0) else begin
            $display("stream bytes arrived after the run had ended");
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Runs

    task automatic run_burst(input logic [31:0] frames);
        write_reg(avmm_regs_pkg::REG_CTRL, 32'h1);
        check_busy_status();
        for (int id = 1; id <= frames; id++) begin
            if (timeouts != 0) break;
            check_frame(id);
        end
        wait_idle();
        check_no_extra_bytes();
    endtask

    task automatic run_continuous(input logic [31:0] min_frames);
        logic [31:0] got;
        int          frames;
        frames = 0;
        write_reg(avmm_regs_pkg::REG_CTRL, 32'h3);
        while (frames < min_frames && timeouts == 0) begin
            frames++;
            check_frame(frames);
        end
        write_reg(avmm_regs_pkg::REG_CTRL, 32'h0);   // Stop after current frame
        wait_idle();
        if (rx_q.size() > 0 && timeouts == 0) begin
            frames++;
            check_frame(frames);
        end
        read_reg(avmm_regs_pkg::REG_DST_MAC_LO, got);
        compare_word("tx_count readback", got, frames);
        check_no_extra_bytes();
    endtask

    initial begin
        logic [63:0]    cmd;
        logic [2047:0]  rest;
        logic [31:0]    arg_a;
        logic [31:0]    arg_b;
        logic [31:0]    got;
        int             fd;
        int             n;
        bus_req = '0;
        rst_n   = 1'b0;
        for (int i = 0; i < 8; i++) begin
            shadow[i] = 32'h0;
        end
        repeat (2) @(posedge clk_ifc_avmm);
        #1;
        rst_n = 1'b1;
        assert (tx_valid === 1'b0) else begin
            $display("error at %0t: tx_valid = %b, expected 0", $time, tx_valid);
            errors++;
        end
        assert (bus_rsp.readdatavalid === 1'b0) else begin
            $display("error at %0t: bus_rsp.readdatavalid = %b, expected 0",
                     $time, bus_rsp.readdatavalid);
            errors++;
        end

        fd = $fopen("verification/pktgen_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            errors++;
        end
        while (fd != 0 && !$feof(fd) && timeouts == 0) begin
            n = $fscanf(fd, "%s", cmd);
            if (n == 1) begin
                if (cmd == 64'("#")) begin
                    n = $fgets(rest, fd);                // Comment line
                end else if (cmd == 64'("w")) begin
                    n = $fscanf(fd, "%h %h", arg_a, arg_b);
                    write_reg(arg_a[2:0], arg_b);
                end else if (cmd == 64'("r")) begin
                    n = $fscanf(fd, "%h %h", arg_a, arg_b);
                    read_reg(arg_a[2:0], got);
                    compare_word($sformatf("readdata (reg %0d)", arg_a), got, arg_b);
                end else if (cmd == 64'("burst")) begin
                    n = $fscanf(fd, "%h", arg_a);
                    run_burst(arg_a);
                end else if (cmd == 64'("cont")) begin
                    n = $fscanf(fd, "%h", arg_a);
                    run_continuous(arg_a);
                end else if (cmd == 64'("bp")) begin
                    n = $fscanf(fd, "%h", arg_a);
                    bp_on <= arg_a[0];
                end else begin
                    $display("unknown trace command %s", cmd);
                    errors++;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/pktgen_trace.txt
# columns: w addr data | r addr expected | burst frames | cont min_frames | bp 0/1
# addr and data in hex; bp 1 turns on random tready gaps
r 0 00000000
w 3 00004011
w 4 c0a80001
w 5 c0a800fe
w 6 00000200
w 7 1a2b3c4d
r 3 00004011
r 4 c0a80001
r 5 c0a800fe
r 6 00000200
w 1 00000003
burst 3
r 0 00000000
r 1 00000000
r 7 00000003
r 2 00000000
bp 1
w 1 00000004
burst 4
r 0 00000000
r 1 00000000
r 7 00000004
w 3 00008006
w 2 0000c000
cont 4
bp 0
cont 3
r 0 00000000

//--- all.f
+incdir+source
source/avmm_regs_pkg.sv
source/ipv4_frame_pkg.sv
source/avmm_reg_bank.sv
source/packet_sequencer.sv
source/ipv4_frame_serializer.sv
source/ipv4_packet_src.sv
verification/tb_ipv4_packet_src.sv

//--- Makefile
TOP = tb_ipv4_packet_src

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
